// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --assert -Wno-fatal
TOP       = tb_smc
FILELIST  = src.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^Everything OK$$"

clean:
	rm -rf obj_dir

// ==== src.f ====
src/smc_pkg.sv
src/smc_apb_regs.sv
src/smc_ahb_slave.sv
src/smc_emi_fsm.sv
src/smc_top.sv
test/emi_sram_model.sv
test/tb_smc.sv

// ==== src/smc_ahb_slave.sv ====
`timescale 1ns/1ps

module smc_ahb_slave
  import smc_pkg::*;
(
  input  logic        hclk,
  input  logic        rst_n,
  input  logic [31:0] haddr,
  input  htrans_e     htrans,
  input  logic        hsel,
  input  logic        hwrite,
  input  hsize_e      hsize,
  input  logic        hready,      // Muxed ready from the bus
  input  smc_timing_t timing,
  input  logic        done,        // Sequencer finished, one cycle
  input  logic [31:0] rd_data,
  output emi_req_t    req,
  output logic        start,       // Address phase of a legal transfer
  output logic [31:0] smc_hrdata,
  output logic        smc_hready,
  output logic [1:0]  smc_hresp,
  output logic        smc_valid
);

  // Data-phase tracking
  typedef enum logic [1:0] {
    ph_idle,  // Ready, OKAY
    ph_busy,  // Waiting on the sequencer
    ph_err1,  // First ERROR cycle, ready low
    ph_err2   // Second ERROR cycle, ready high
  } ahb_phase_e;

  ahb_phase_e phase;
  logic       accept;
  logic       legal;

  // Little-endian lane select
  function automatic logic [3:0] lane_decode(hsize_e size, logic [1:0] addr_lo);
    logic [3:0] lanes;
    case (size)
      hsize_byte: lanes = 4'b0001 << addr_lo;
      hsize_half: lanes = addr_lo[1] ? 4'b1100 : 4'b0011;
      default:    lanes = 4'b1111;
    endcase
    return lanes;
  endfunction

  // ----------------------------------------
  // Address phase
  // ----------------------------------------

  assign accept = hsel && hready && (htrans == htrans_nonseq || htrans == htrans_seq);
  assign legal  = (hsize <= hsize_word) && timing.enable;  // Size and global enable
  assign start  = accept && legal;

  assign req.addr  = haddr;
  assign req.be    = lane_decode(hsize, haddr[1:0]);
  assign req.write = hwrite;

  // ----------------------------------------
  // Data phase
  // ----------------------------------------

  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      phase     <= ph_idle;
      smc_valid <= 1'b0;
    end else begin
      smc_valid <= accept;  // Ack for every accepted address
      case (phase)
        ph_busy: if (done) phase <= ph_idle;
        ph_err1: phase <= ph_err2;
        default: begin      // Ready cycles take a new address
          if (accept) phase <= legal ? ph_busy : ph_err1;
          else        phase <= ph_idle;
        end
      endcase
    end
  end

  // Read data lands with the ready cycle
  always_ff @(posedge hclk) begin
    if (done) begin
      smc_hrdata <= rd_data;
    end
  end

  assign smc_hready = (phase == ph_idle) || (phase == ph_err2);
  assign smc_hresp  = (phase == ph_err1 || phase == ph_err2) ? HRESP_ERROR : HRESP_OKAY;

  // Accepted illegal transfer: low ready, then high ready, then out of it
  a_err_two_cycle: assert property (@(posedge hclk) disable iff (!rst_n)
    (accept && !legal) |=>
      (smc_hresp == HRESP_ERROR && !smc_hready) ##1
      (smc_hresp == HRESP_ERROR && smc_hready) ##1
      !(smc_hresp == HRESP_ERROR && smc_hready))
    else $error("ERROR response not exactly two cycles");

  // Bus ready must mirror our own while a transfer is open
  a_no_start_outstanding: assert property (@(posedge hclk) disable iff (!rst_n)
    start |-> smc_hready)
    else $error("start issued with a transfer outstanding");

endmodule

// ==== src/smc_apb_regs.sv ====
`timescale 1ns/1ps

module smc_apb_regs
  import smc_pkg::*;
(
  input  logic        hclk,
  input  logic        rst_n,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [4:0]  paddr,
  input  logic [31:0] pwdata,
  input  logic        busy,     // From sequencer
  output logic [31:0] prdata,
  output smc_timing_t timing    // To slave and sequencer
);

  logic wr_en;

  // Access phase of an APB write, no wait states
  assign wr_en = psel & penable & pwrite;

  // ----------------------------------------
  // Register writes
  // ----------------------------------------

  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      timing <= TIMING_RESET;
    end else if (wr_en) begin
      case (paddr)
        REG_TIMING: begin
          timing.rd_wait <= pwdata[3:0];
          timing.wr_wait <= pwdata[7:4];
        end
        REG_CTRL: timing.enable <= pwdata[0];
        default: ;  // STATUS and holes ignore writes
      endcase
    end
  end

  // ----------------------------------------
  // Read mux
  // ----------------------------------------

  always_comb begin
    prdata = '0;  // Unmapped offsets read zero
    case (paddr)
      REG_TIMING: prdata[7:0] = {timing.wr_wait, timing.rd_wait};
      REG_CTRL:   prdata[0]   = timing.enable;
      REG_STATUS: prdata[0]   = busy;          // Live sequencer state
      default:    prdata      = '0;
    endcase
  end

  // Access phase must sit inside a selected transfer
  a_penable_psel: assert property (@(posedge hclk) disable iff (!rst_n)
    penable |-> psel)
    else $error("APB penable high without psel");

endmodule

// ==== src/smc_emi_fsm.sv ====
`timescale 1ns/1ps

module smc_emi_fsm
  import smc_pkg::*;
#(
  parameter int EMI_ADDR_W = 24  // External address width
) (
  input  logic        hclk,
  input  logic        rst_n,
  input  logic        start,
  input  emi_req_t    req,
  input  logic [31:0] hwdata,
  input  smc_timing_t timing,
  input  logic [31:0] data_smc,    // Read data from the pins
  output logic        done,
  output logic [31:0] rd_data,
  output logic        busy,
  output logic [31:0] smc_addr,
  output logic [31:0] smc_data,
  output logic [3:0]  smc_n_be,
  output logic        smc_n_cs,
  output logic        smc_n_wr,
  output logic [3:0]  smc_n_we,
  output logic        smc_n_rd,
  output logic        smc_n_ext_oe
);

  emi_state_e            state;
  logic [3:0]            wait_cnt;   // Remaining extra access cycles
  logic                  write_r;
  logic [EMI_ADDR_W-1:0] addr_r;
  logic                  last_access;

  assign last_access = (state == st_access) && (wait_cnt == 4'd0);

  // ----------------------------------------
  // Sequencer and strobes
  // ----------------------------------------

  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= st_idle;
      wait_cnt     <= '0;
      write_r      <= 1'b0;
      smc_n_cs     <= 1'b1;
      smc_n_be     <= 4'hf;
      smc_n_rd     <= 1'b1;
      smc_n_wr     <= 1'b1;
      smc_n_we     <= 4'hf;
      smc_n_ext_oe <= 1'b1;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            state        <= st_setup;
            write_r      <= req.write;
            wait_cnt     <= req.write ? timing.wr_wait : timing.rd_wait;
            smc_n_cs     <= 1'b0;
            smc_n_be     <= ~req.be;
            smc_n_ext_oe <= ~req.write;  // Drive pins only on writes
          end
        end
        st_setup: begin
          state <= st_access;
          if (write_r) begin
            smc_n_wr <= 1'b0;
            smc_n_we <= smc_n_be;        // Lane strobes follow byte enables
          end else begin
            smc_n_rd <= 1'b0;
          end
        end
        st_access: begin
          if (last_access) begin
            state    <= st_hold;
            smc_n_rd <= 1'b1;
            smc_n_wr <= 1'b1;
            smc_n_we <= 4'hf;
          end else begin
            wait_cnt <= wait_cnt - 4'd1;
          end
        end
        default: begin                   // st_hold, release the bus
          state        <= st_idle;
          smc_n_cs     <= 1'b1;
          smc_n_be     <= 4'hf;
          smc_n_ext_oe <= 1'b1;
        end
      endcase
    end
  end

  // ----------------------------------------
  // Address and data
  // ----------------------------------------

  always_ff @(posedge hclk) begin
    if (state == st_idle && start) begin
      addr_r <= req.addr[EMI_ADDR_W-1:0];
    end
    if (state == st_setup && write_r) begin
      smc_data <= hwdata;                // Data phase of the write
    end
    if (last_access && !write_r) begin
      rd_data <= data_smc;               // Sampled at end of strobe
    end
  end

  assign smc_addr = 32'(addr_r);         // Upper bits zero
  assign done     = (state == st_hold);
  assign busy     = (state != st_idle);

  a_rd_wr_exclusive: assert property (@(posedge hclk) disable iff (!rst_n)
    !(!smc_n_rd && !smc_n_wr))
    else $error("EMI read and write strobes low together");

  a_strobe_needs_cs: assert property (@(posedge hclk) disable iff (!rst_n)
    (!smc_n_rd || !smc_n_wr) |-> !smc_n_cs)
    else $error("EMI strobe low without chip select");

endmodule

// ==== src/smc_pkg.sv ====
package smc_pkg;

  // ----------------------------------------
  // AHB encodings
  // ----------------------------------------

  typedef enum logic [1:0] {
    htrans_idle   = 2'b00,  // No transfer
    htrans_busy   = 2'b01,  // Master inserting idle beat
    htrans_nonseq = 2'b10,  // Single or first beat
    htrans_seq    = 2'b11   // Follow-on beat
  } htrans_e;

  // Sizes above word are illegal here
  typedef enum logic [2:0] {
    hsize_byte = 3'b000,
    hsize_half = 3'b001,
    hsize_word = 3'b010
  } hsize_e;

  localparam logic [1:0] HRESP_OKAY  = 2'b00;
  localparam logic [1:0] HRESP_ERROR = 2'b01;

  // ----------------------------------------
  // EMI sequencer
  // ----------------------------------------

  typedef enum logic [1:0] {
    st_idle,    // Bus parked, all strobes high
    st_setup,   // CS, address and lanes out
    st_access,  // Strobe low for wait + 1 cycles
    st_hold     // Strobe released, CS still low
  } emi_state_e;

  // One transfer handed from the AHB side to the sequencer
  typedef struct packed {
    logic [31:0] addr;
    logic [3:0]  be;     // Active high lane enables
    logic        write;
  } emi_req_t;

  // Register contents seen by the datapath
  typedef struct packed {
    logic [3:0] rd_wait;
    logic [3:0] wr_wait;
    logic       enable;
  } smc_timing_t;

  // ----------------------------------------
  // APB register map
  // ----------------------------------------

  localparam logic [4:0] REG_TIMING = 5'h00;  // [3:0] rd_wait, [7:4] wr_wait
  localparam logic [4:0] REG_CTRL   = 5'h04;  // [0] enable
  localparam logic [4:0] REG_STATUS = 5'h08;  // [0] busy, read only

  localparam smc_timing_t TIMING_RESET = '{rd_wait: 4'd2, wr_wait: 4'd1, enable: 1'b1};

endpackage

// ==== src/smc_top.sv ====
`timescale 1ns/1ps

module smc_top
  import smc_pkg::*;
#(
  parameter int EMI_ADDR_W = 24
) (
  input  logic        hclk,
  input  logic        rst_n,
  // APB
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [4:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  // AHB-lite
  input  logic [31:0] haddr,
  input  htrans_e     htrans,
  input  logic        hsel,
  input  logic        hwrite,
  input  hsize_e      hsize,
  input  logic [31:0] hwdata,
  input  logic        hready,
  output logic [31:0] smc_hrdata,
  output logic        smc_hready,
  output logic [1:0]  smc_hresp,
  output logic        smc_valid,
  // EMI
  input  logic [31:0] data_smc,
  output logic [31:0] smc_addr,
  output logic [31:0] smc_data,
  output logic [3:0]  smc_n_be,
  output logic        smc_n_cs,
  output logic        smc_n_wr,
  output logic [3:0]  smc_n_we,
  output logic        smc_n_rd,
  output logic        smc_n_ext_oe,
  output logic        smc_busy
);

  smc_timing_t timing;
  emi_req_t    req;
  logic        start;
  logic        done;
  logic [31:0] rd_data;

  smc_apb_regs i_apb_regs (
    .hclk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
    .busy(smc_busy), .prdata, .timing
  );

  smc_ahb_slave i_ahb_slave (
    .hclk, .rst_n, .haddr, .htrans, .hsel, .hwrite, .hsize, .hready,
    .timing, .done, .rd_data, .req, .start,
    .smc_hrdata, .smc_hready, .smc_hresp, .smc_valid
  );

  smc_emi_fsm #(.EMI_ADDR_W(EMI_ADDR_W)) i_emi_fsm (
    .hclk, .rst_n, .start, .req, .hwdata, .timing, .data_smc,
    .done, .rd_data, .busy(smc_busy),
    .smc_addr, .smc_data, .smc_n_be, .smc_n_cs, .smc_n_wr,
    .smc_n_we, .smc_n_rd, .smc_n_ext_oe
  );

endmodule

// ==== test/emi_sram_model.sv ====
`timescale 1ns/1ps

module emi_sram_model (
  input  logic        hclk,
  input  logic [31:0] smc_addr,
  input  logic [31:0] smc_data,
  input  logic        smc_n_cs,
  input  logic        smc_n_rd,
  input  logic [3:0]  smc_n_we,
  output logic [31:0] data_smc
);

  logic [31:0] mem [0:255];  // 256 words, four byte lanes each
  logic [7:0]  idx;

  assign idx = smc_addr[9:2];  // Word index

  // Drives the pins only while the read strobe is low
  assign data_smc = (!smc_n_cs && !smc_n_rd) ? mem[idx] : 32'h0;

  // Byte lanes written on each selected edge
  always @(posedge hclk) begin
    if (!smc_n_cs) begin
      for (int b = 0; b < 4; b++) begin
        if (!smc_n_we[b]) begin
          mem[idx][8*b +: 8] <= smc_data[8*b +: 8];
        end
      end
    end
  end

endmodule

// ==== test/tb_smc.sv ====
`timescale 1ns/1ps

module tb_smc
  import smc_pkg::*;
();

  localparam int EMI_ADDR_W = 24;
  localparam int MAX_CYCLES = 3000;  // About 370 cycles of tests, wide margin

  logic        hclk, rst_n;
  logic        psel, penable, pwrite;
  logic [4:0]  paddr;
  logic [31:0] pwdata, prdata;
  logic [31:0] haddr, hwdata, smc_hrdata, data_smc;
  htrans_e     htrans;
  hsize_e      hsize;
  logic        hsel, hwrite, hready, smc_hready, smc_valid;
  logic [1:0]  smc_hresp;
  logic [31:0] smc_addr, smc_data;
  logic [3:0]  smc_n_be, smc_n_we;
  logic        smc_n_cs, smc_n_wr, smc_n_rd, smc_n_ext_oe, smc_busy;

  int          errors = 0;
  int          cycles = 0;
  int          rd_low = 0;       // Running count of cycles with a strobe low
  int          wr_low = 0;
  int          cs_low = 0;
  int          oe_low = 0;       // Write data driven onto the pins
  logic [31:0] rng;
  logic [31:0] ref_mem [0:255];  // Expected SRAM contents
  logic [1:0]  last_first, last_resp;  // Hresp in first and final data cycle
  logic [31:0] last_rdata;
  logic        last_busy;        // Busy in first data cycle
  int          last_lows;        // Data-phase cycles with hready low

  smc_top #(.EMI_ADDR_W(EMI_ADDR_W)) dut0 (.*);
  emi_sram_model sram0 (.*);

  assign hready = smc_hready;  // Only slave on the bus

  initial begin
    hclk = 1'b0;
    forever #4 hclk = ~hclk;
  end

  // ----------------------------------------
  // Monitors and timeout
  // ----------------------------------------

  always @(negedge hclk) begin
    if (!smc_n_rd) rd_low++;
    if (!smc_n_wr) wr_low++;
    if (!smc_n_cs) cs_low++;
    if (!smc_n_ext_oe) oe_low++;
  end

  always @(posedge hclk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Something failed");
      $finish;
    end
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Little-endian lanes for size and low address bits
  function automatic logic [3:0] lanes_for(input logic [2:0] size, input logic [1:0] a);
    if (size == 3'd0) return 4'b0001 << a;
    if (size == 3'd1) return a[1] ? 4'b1100 : 4'b0011;
    return 4'b1111;
  endfunction

  function automatic logic [31:0] merge_lanes(input logic [31:0] old_d, input logic [31:0] new_d,
                                              input logic [3:0] lanes);
    logic [31:0] m;
    m = old_d;
    for (int b = 0; b < 4; b++) begin
      if (lanes[b]) m[8*b +: 8] = new_d[8*b +: 8];
    end
    return m;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t ns: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic apb_write(input logic [4:0] addr, input logic [31:0] data);
    @(negedge hclk);
    psel    = 1'b1;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge hclk);
    penable = 1'b1;  // Access phase, write lands on next edge
    @(negedge hclk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_read(input logic [4:0] addr, output logic [31:0] data);
    @(negedge hclk);
    psel    = 1'b1;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge hclk);
    penable = 1'b1;
    @(negedge hclk);
    data    = prdata;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // One single transfer, address phase then data phase until hready
  task automatic ahb_transfer(input logic wr, input logic [2:0] size, input logic [31:0] addr,
                              input logic [31:0] wdata);
    @(negedge hclk);
    haddr      = addr;
    hwrite     = wr;
    hsize      = hsize_e'(size);
    htrans     = htrans_nonseq;
    hsel       = 1'b1;
    @(negedge hclk);  // First data-phase cycle
    htrans     = htrans_idle;
    hsel       = 1'b0;
    hwdata     = wdata;
    last_first = smc_hresp;
    last_busy  = smc_busy;
    last_lows  = 0;
    check_value("smc_valid in first data cycle", smc_valid, 1);
    while (!smc_hready) begin
      last_lows++;
      @(negedge hclk);
    end
    last_rdata = smc_hrdata;
    last_resp  = smc_hresp;
    check_value("smc_valid in final data cycle", smc_valid, 0);  // One-cycle pulse
  endtask

  task automatic ahb_write(input logic [2:0] size, input logic [31:0] addr,
                           input logic [31:0] data);
    ahb_transfer(1'b1, size, addr, data);
  endtask

  task automatic ahb_read(input logic [2:0] size, input logic [31:0] addr,
                          output logic [31:0] data);
    ahb_transfer(1'b0, size, addr, 32'h0);
    data = last_rdata;
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------

  task automatic reset_values();
    logic [31:0] d;
    check_value("hready after reset", smc_hready, 1);
    check_value("hresp after reset", smc_hresp, HRESP_OKAY);
    check_value("busy after reset", smc_busy, 0);
    check_value("EMI controls after reset",
                {smc_n_cs, smc_n_rd, smc_n_wr, smc_n_ext_oe, smc_n_we, smc_n_be}, 12'hfff);
    apb_read(REG_TIMING, d);
    check_value("TIMING reset", d, 32'h0000_0012);  // wr_wait 1, rd_wait 2
    apb_read(REG_CTRL, d);
    check_value("CTRL reset", d, 32'h1);
  endtask

  task automatic register_access();
    logic [31:0] v, c, d;
    for (int i = 0; i < 3; i++) begin
      rng = xorshift32(rng);
      v   = rng;
      rng = xorshift32(rng);
      c   = rng;
      apb_write(REG_TIMING, v);
      apb_write(REG_CTRL, c);
      apb_read(REG_TIMING, d);
      check_value("TIMING readback", d, v & 32'hff);
      apb_read(REG_CTRL, d);
      check_value("CTRL readback", d, c & 32'h1);
      apb_read(REG_STATUS, d);
      check_value("STATUS idle", d, 0);
      apb_write(REG_STATUS, 32'hffff_ffff);  // Read only
      apb_read(REG_STATUS, d);
      check_value("STATUS after write", d, 0);
      apb_read(REG_TIMING, d);
      check_value("TIMING after STATUS write", d, v & 32'hff);
    end
    apb_write(REG_CTRL, 32'h1);
    apb_write(REG_TIMING, 32'h12);
  endtask

  task automatic word_access();
    logic [31:0] addr [4];
    logic [31:0] d;
    for (int i = 0; i < 4; i++) begin
      rng     = xorshift32(rng);
      addr[i] = {rng[31:10], 8'(i * 37 + 5), 2'b00};  // Upper bits random, index spread
      rng     = xorshift32(rng);
      ref_mem[addr[i][9:2]] = rng;
      ahb_write(3'd2, addr[i], rng);
      check_value("word write resp", {last_first, last_resp}, {HRESP_OKAY, HRESP_OKAY});
      check_value("busy during word write", last_busy, 1);
      check_value("smc_addr", smc_addr, addr[i] & ((32'd1 << EMI_ADDR_W) - 1));
    end
    for (int i = 0; i < 4; i++) begin
      ahb_read(3'd2, addr[i], d);
      check_value("word read data", d, ref_mem[addr[i][9:2]]);
      check_value("word read resp", last_resp, HRESP_OKAY);
    end
  endtask

  task automatic partial_writes();
    logic [31:0] base, d;
    logic [2:0]  sz;
    logic [1:0]  off;
    base = 32'h0000_0320;
    rng  = xorshift32(rng);
    ref_mem[base[9:2]] = rng;
    ahb_write(3'd2, base, rng);  // Known starting word
    for (int k = 0; k < 6; k++) begin  // Four bytes, then two halfwords
      sz  = (k < 4) ? 3'd0 : 3'd1;
      off = (k < 4) ? 2'(k) : ((k == 4) ? 2'd0 : 2'd2);
      rng = xorshift32(rng);
      ref_mem[base[9:2]] = merge_lanes(ref_mem[base[9:2]], rng, lanes_for(sz, off));
      ahb_write(sz, {base[31:2], off}, rng);
      ahb_read(3'd2, base, d);
      check_value("partial write merge", d, ref_mem[base[9:2]]);
    end
  endtask

  task automatic wait_states();
    int          rd0, wr0, oe0;
    logic [31:0] d;
    logic [3:0]  w, wr_w;
    for (int k = 0; k < 4; k++) begin
      w    = 4'(k * 5);  // 0, 5, 10, 15
      wr_w = ~w;
      apb_write(REG_TIMING, {24'h0, wr_w, w});
      rng  = xorshift32(rng);
      ref_mem[8'h10] = rng;
      wr0  = wr_low;
      oe0  = oe_low;
      ahb_write(3'd2, 32'h0000_0040, rng);
      check_value("write strobe cycles", wr_low - wr0, wr_w + 1);
      check_value("write hready low cycles", last_lows, wr_w + 3);
      check_value("write data enable cycles", oe_low - oe0, wr_w + 3);  // Setup to hold
      rd0  = rd_low;
      oe0  = oe_low;
      ahb_read(3'd2, 32'h0000_0040, d);
      check_value("read strobe cycles", rd_low - rd0, w + 1);
      check_value("read hready low cycles", last_lows, w + 3);
      check_value("data enable during read", oe_low - oe0, 0);
      check_value("wait-state read data", d, ref_mem[8'h10]);
    end
    apb_write(REG_TIMING, 32'h12);
  endtask

  task automatic error_responses();
    int          cs0;
    logic [31:0] d;
    cs0 = cs_low;
    ahb_write(3'b011, 32'h0000_0040, 32'hdead_beef);  // Doubleword, too wide
    check_value("oversize ERROR response", {last_first, last_resp, 8'(last_lows)},
                {HRESP_ERROR, HRESP_ERROR, 8'd1});
    check_value("busy during oversize ERROR", last_busy, 0);
    apb_write(REG_CTRL, 32'h0);
    ahb_write(3'd2, 32'h0000_0040, 32'h1234_5678);
    check_value("disabled ERROR response", {last_first, last_resp, 8'(last_lows)},
                {HRESP_ERROR, HRESP_ERROR, 8'd1});
    check_value("busy during disabled ERROR", last_busy, 0);
    apb_write(REG_CTRL, 32'h1);
    check_value("cs low cycles during errors", cs_low - cs0, 0);
    ahb_read(3'd2, 32'h0000_0040, d);
    check_value("memory after errors", d, ref_mem[8'h10]);
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------

  initial begin
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    haddr   = '0;
    hwdata  = '0;
    htrans  = htrans_idle;
    hsize   = hsize_word;
    hsel    = 1'b0;
    hwrite  = 1'b0;
    rng     = 32'd55;
    repeat (16) @(negedge hclk);
    rst_n = 1'b1;
    @(negedge hclk);
    reset_values();
    register_access();
    word_access();
    partial_writes();
    wait_states();
    error_responses();
    $display("Checks done, errors: %0d", errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
